// ==== calib_pkg.sv ====
package calib_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample and calibration types
  //////////////////////////////////////////////////////////////////////

  // converter sample, both directions
  typedef logic signed [14-1:0] sample_t;
  // gain in fixed point, GAIN_FRAC fractional bits
  typedef logic signed [16-1:0] gain_t;
  // offset added after gain, same scale as sample
  typedef logic signed [14-1:0] offset_t;

  // raw ADC pin word, two low bits reserved
  localparam int unsigned ADC_RAW_W = 16;
  localparam int unsigned GAIN_FRAC = 13;
  // gain reset value, 1.0
  localparam gain_t       GAIN_UNITY = 16'h2000;

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite and register map
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AXIL_AW = 8;
  localparam int unsigned AXIL_DW = 32;

  // read-only identification word
  localparam logic [AXIL_DW-1:0] CALIB_ID = 32'h5043_0001;

  localparam logic [AXIL_AW-1:0] REG_ID       = 8'h00;
  localparam logic [AXIL_AW-1:0] REG_LOOP     = 8'h04;
  localparam logic [AXIL_AW-1:0] REG_ADC_BASE = 8'h40;
  localparam logic [AXIL_AW-1:0] REG_DAC_BASE = 8'h80;
  // bytes between channels
  localparam int unsigned REG_CH_STRIDE = 8;
  // position inside one channel stride
  localparam int unsigned REG_MUL_OFS = 0;
  localparam int unsigned REG_SUM_OFS = 4;

endpackage: calib_pkg

// ==== calib_cfg_if.sv ====
// calibration and loopback settings, one entry per channel
interface calib_cfg_if #(
  parameter int unsigned NCH = 2
);

  // ADC side gain and offset
  calib_pkg::gain_t   adc_mul [NCH];
  calib_pkg::offset_t adc_sum [NCH];
  // DAC side gain and offset
  calib_pkg::gain_t   dac_mul [NCH];
  calib_pkg::offset_t dac_sum [NCH];
  // digital loopback DAC -> ADC
  logic [NCH-1:0]     loop;

  // register block owns all settings
  modport regs (
    output adc_mul, adc_sum, dac_mul, dac_sum, loop
  );

  // channel banks only consume them
  modport chan (
    input  adc_mul, adc_sum, dac_mul, dac_sum, loop
  );

endinterface: calib_cfg_if

// ==== calib_regs.sv ====
module calib_regs #(
  parameter int unsigned NCH = 2
)(
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // write address
  input  logic [calib_pkg::AXIL_AW-1:0] s_axil_awaddr_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,
  // write data
  input  logic [calib_pkg::AXIL_DW-1:0] s_axil_wdata_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,
  // write response
  output logic [2-1:0]                  s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,
  // read address
  input  logic [calib_pkg::AXIL_AW-1:0] s_axil_araddr_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,
  // read data
  output logic [calib_pkg::AXIL_DW-1:0] s_axil_rdata_o,
  output logic [2-1:0]                  s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i,
  // settings toward channel banks
  calib_cfg_if.regs                     cfg
);

localparam int unsigned AW = calib_pkg::AXIL_AW;
localparam int unsigned DW = calib_pkg::AXIL_DW;

logic          wr_acc;
logic          rd_acc;
logic [DW-1:0] rd_val;

// byte address of one channel register
function automatic logic [AW-1:0] ch_addr(
  input logic [AW-1:0] base,
  input int unsigned   ch,
  input int unsigned   ofs
);
  return base + AW'(ch * calib_pkg::REG_CH_STRIDE + ofs);
endfunction

//////////////////////////////////////////////////////////////////////
// write channel
//////////////////////////////////////////////////////////////////////

// address and data taken together, only with no response pending
assign s_axil_awready_o = ~s_axil_bvalid_o;
assign s_axil_wready_o  = ~s_axil_bvalid_o;
assign wr_acc = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;

// always OKAY
assign s_axil_bresp_o = 2'b00;

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    s_axil_bvalid_o <= 1'b0;
  end else if (wr_acc) begin
    s_axil_bvalid_o <= 1'b1;
  end else if (s_axil_bready_i) begin
    s_axil_bvalid_o <= 1'b0;
  end
end

// settings update on the same edge that raises bvalid
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    cfg.loop    <= '0;
    cfg.adc_mul <= '{default: calib_pkg::GAIN_UNITY};
    cfg.adc_sum <= '{default: '0};
    cfg.dac_mul <= '{default: calib_pkg::GAIN_UNITY};
    cfg.dac_sum <= '{default: '0};
  end else if (wr_acc) begin
    if (s_axil_awaddr_i == calib_pkg::REG_LOOP) begin
      cfg.loop <= s_axil_wdata_i[NCH-1:0];
    end
    // unmapped offsets match nothing and are dropped
    for (int i = 0; i < NCH; i++) begin
      if (s_axil_awaddr_i == ch_addr(calib_pkg::REG_ADC_BASE, i, calib_pkg::REG_MUL_OFS))
        cfg.adc_mul[i] <= s_axil_wdata_i[$bits(calib_pkg::gain_t)-1:0];
      if (s_axil_awaddr_i == ch_addr(calib_pkg::REG_ADC_BASE, i, calib_pkg::REG_SUM_OFS))
        cfg.adc_sum[i] <= s_axil_wdata_i[$bits(calib_pkg::offset_t)-1:0];
      if (s_axil_awaddr_i == ch_addr(calib_pkg::REG_DAC_BASE, i, calib_pkg::REG_MUL_OFS))
        cfg.dac_mul[i] <= s_axil_wdata_i[$bits(calib_pkg::gain_t)-1:0];
      if (s_axil_awaddr_i == ch_addr(calib_pkg::REG_DAC_BASE, i, calib_pkg::REG_SUM_OFS))
        cfg.dac_sum[i] <= s_axil_wdata_i[$bits(calib_pkg::offset_t)-1:0];
    end
  end
end

//////////////////////////////////////////////////////////////////////
// read channel
//////////////////////////////////////////////////////////////////////

assign s_axil_arready_o = ~s_axil_rvalid_o;
assign rd_acc = s_axil_arvalid_i & ~s_axil_rvalid_o;
assign s_axil_rresp_o = 2'b00;

// read decode, gains and offsets come back sign extended
always_comb begin
  rd_val = '0;
  if (s_axil_araddr_i == calib_pkg::REG_ID)   rd_val = calib_pkg::CALIB_ID;
  if (s_axil_araddr_i == calib_pkg::REG_LOOP) rd_val = DW'(cfg.loop);
  for (int i = 0; i < NCH; i++) begin
    if (s_axil_araddr_i == ch_addr(calib_pkg::REG_ADC_BASE, i, calib_pkg::REG_MUL_OFS))
      rd_val = DW'(cfg.adc_mul[i]);
    if (s_axil_araddr_i == ch_addr(calib_pkg::REG_ADC_BASE, i, calib_pkg::REG_SUM_OFS))
      rd_val = DW'(cfg.adc_sum[i]);
    if (s_axil_araddr_i == ch_addr(calib_pkg::REG_DAC_BASE, i, calib_pkg::REG_MUL_OFS))
      rd_val = DW'(cfg.dac_mul[i]);
    if (s_axil_araddr_i == ch_addr(calib_pkg::REG_DAC_BASE, i, calib_pkg::REG_SUM_OFS))
      rd_val = DW'(cfg.dac_sum[i]);
  end
end

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    s_axil_rvalid_o <= 1'b0;
  end else if (rd_acc) begin
    s_axil_rvalid_o <= 1'b1;
  end else if (s_axil_rready_i) begin
    s_axil_rvalid_o <= 1'b0;
  end
end

// read data loads only on acceptance, held while rvalid
always_ff @(posedge adc_clk) begin
  if (rd_acc) begin
    s_axil_rdata_o <= rd_val;
  end
end

// responses wait for the master
ast_bvalid_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
  s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

ast_rvalid_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
  s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o));

endmodule: calib_regs

// ==== linear_calib.sv ====
module linear_calib (
  input  logic               adc_clk,
  input  logic               top_rst,
  // input sample
  input  calib_pkg::sample_t dat_i,
  input  logic               vld_i,
  // gain and offset
  input  calib_pkg::gain_t   mul_i,
  input  calib_pkg::offset_t sum_i,
  // calibrated sample
  output calib_pkg::sample_t dat_o,
  output logic               vld_o
);

localparam int unsigned DW = $bits(calib_pkg::sample_t);
// full product width
localparam int unsigned PW = DW + $bits(calib_pkg::gain_t);
// shifted product plus offset, one guard bit
localparam int unsigned SW = PW - calib_pkg::GAIN_FRAC + 1;

// saturation limits at accumulator width
localparam logic signed [SW-1:0] SAT_MAX = {{(SW-DW+1){1'b0}}, {(DW-1){1'b1}}};
localparam logic signed [SW-1:0] SAT_MIN = {{(SW-DW+1){1'b1}}, {(DW-1){1'b0}}};

logic signed [PW-1:0] prod_q;
calib_pkg::offset_t   sum_q;
logic                 vld_q;
logic signed [SW-1:0] acc;

//////////////////////////////////////////////////////////////////////
// stage one, multiply
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk) begin
  prod_q <= dat_i * mul_i;
  sum_q  <= sum_i;
end

//////////////////////////////////////////////////////////////////////
// stage two, shift, add offset, saturate
//////////////////////////////////////////////////////////////////////

// arithmetic shift drops the fraction
assign acc = SW'(prod_q >>> calib_pkg::GAIN_FRAC) + SW'(sum_q);

always_ff @(posedge adc_clk) begin
  if (acc > SAT_MAX) begin
    dat_o <= SAT_MAX[DW-1:0];
  end else if (acc < SAT_MIN) begin
    dat_o <= SAT_MIN[DW-1:0];
  end else begin
    dat_o <= acc[DW-1:0];
  end
end

// valid travels alongside data
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    vld_q <= 1'b0;
    vld_o <= 1'b0;
  end else begin
    vld_q <= vld_i;
    vld_o <= vld_q;
  end
end

// exactly two cycles, no bubbles and no drops
ast_vld_lat: assert property (@(posedge adc_clk) disable iff (top_rst)
  1'b1 |-> ##2 (vld_o == $past(vld_i, 2)));

endmodule: linear_calib

// ==== adc_bank.sv ====
module adc_bank #(
  parameter int unsigned NCH = 2
)(
  input  logic                                       adc_clk,
  input  logic                                       top_rst,
  // raw converter pins
  input  logic [NCH-1:0][calib_pkg::ADC_RAW_W-1:0]   adc_dat_i,
  // calibrated DAC samples for loopback
  input  calib_pkg::sample_t [NCH-1:0]               lpb_dat_i,
  input  logic [NCH-1:0]                             lpb_vld_i,
  // settings
  calib_cfg_if.chan                                  cfg,
  // toward instruments
  output calib_pkg::sample_t [NCH-1:0]               osc_dat_o,
  output logic [NCH-1:0]                             osc_vld_o
);

localparam int unsigned RW = calib_pkg::ADC_RAW_W;

// pins carry a new word every cycle once out of reset
logic cap_vld;

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    cap_vld <= 1'b0;
  end else begin
    cap_vld <= 1'b1;
  end
end

//////////////////////////////////////////////////////////////////////
// per channel capture, loopback, calibration
//////////////////////////////////////////////////////////////////////

for (genvar i = 0; i < NCH; i++) begin: g_ch

  calib_pkg::sample_t cap_dat;
  calib_pkg::sample_t mux_dat;
  logic               mux_vld;

  // capture register at the pins
  // offset binary, negative slope -> signed, low two bits unused
  always_ff @(posedge adc_clk) begin
    cap_dat <= {adc_dat_i[i][RW-1], ~adc_dat_i[i][RW-2:2]};
  end

  // loopback bypasses the capture stage
  assign mux_dat = cfg.loop[i] ? lpb_dat_i[i] : cap_dat;
  assign mux_vld = cfg.loop[i] ? lpb_vld_i[i] : cap_vld;

  linear_calib linear_adc (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (mux_dat),
    .vld_i   (mux_vld),
    .mul_i   (cfg.adc_mul[i]),
    .sum_i   (cfg.adc_sum[i]),
    .dat_o   (osc_dat_o[i]),
    .vld_o   (osc_vld_o[i])
  );

  // data behind a valid flag is always resolved
  ast_osc_known: assert property (@(posedge adc_clk) disable iff (top_rst)
    osc_vld_o[i] |-> !$isunknown(osc_dat_o[i]));

end: g_ch

endmodule: adc_bank

// ==== dac_bank.sv ====
module dac_bank #(
  parameter int unsigned NCH = 2
)(
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // generator samples
  input  calib_pkg::sample_t [NCH-1:0] gen_dat_i,
  input  logic [NCH-1:0]               gen_vld_i,
  // settings
  calib_cfg_if.chan                    cfg,
  // calibrated samples, also fed back to the ADC side
  output calib_pkg::sample_t [NCH-1:0] lpb_dat_o,
  output logic [NCH-1:0]               lpb_vld_o,
  // DAC pin code
  output logic [NCH-1:0][14-1:0]       dac_dat_o
);

localparam int unsigned DW = $bits(calib_pkg::sample_t);

//////////////////////////////////////////////////////////////////////
// per channel calibration and output register
//////////////////////////////////////////////////////////////////////

for (genvar i = 0; i < NCH; i++) begin: g_ch

  linear_calib linear_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (gen_dat_i[i]),
    .vld_i   (gen_vld_i[i]),
    .mul_i   (cfg.dac_mul[i]),
    .sum_i   (cfg.dac_sum[i]),
    .dat_o   (lpb_dat_o[i]),
    .vld_o   (lpb_vld_o[i])
  );

  // signed -> offset binary with negative slope
  // holds last code while no valid sample arrives
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o[i] <= '0;
    end else if (lpb_vld_o[i]) begin
      dac_dat_o[i] <= {lpb_dat_o[i][DW-1], ~lpb_dat_o[i][DW-2:0]};
    end
  end

end: g_ch

endmodule: dac_bank

// ==== rp_analog_top.sv ====
module rp_analog_top #(
  parameter int unsigned NCH = 2
)(
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  // AXI4-Lite register access
  input  logic [calib_pkg::AXIL_AW-1:0]            s_axil_awaddr_i,
  input  logic                                     s_axil_awvalid_i,
  output logic                                     s_axil_awready_o,
  input  logic [calib_pkg::AXIL_DW-1:0]            s_axil_wdata_i,
  input  logic                                     s_axil_wvalid_i,
  output logic                                     s_axil_wready_o,
  output logic [2-1:0]                             s_axil_bresp_o,
  output logic                                     s_axil_bvalid_o,
  input  logic                                     s_axil_bready_i,
  input  logic [calib_pkg::AXIL_AW-1:0]            s_axil_araddr_i,
  input  logic                                     s_axil_arvalid_i,
  output logic                                     s_axil_arready_o,
  output logic [calib_pkg::AXIL_DW-1:0]            s_axil_rdata_o,
  output logic [2-1:0]                             s_axil_rresp_o,
  output logic                                     s_axil_rvalid_o,
  input  logic                                     s_axil_rready_i,
  // ADC pins
  input  logic [NCH-1:0][calib_pkg::ADC_RAW_W-1:0] adc_dat_i,
  // generator samples in place of the signal generators
  input  calib_pkg::sample_t [NCH-1:0]             gen_dat_i,
  input  logic [NCH-1:0]                           gen_vld_i,
  // toward instruments
  output calib_pkg::sample_t [NCH-1:0]             osc_dat_o,
  output logic [NCH-1:0]                           osc_vld_o,
  // DAC pins
  output logic [NCH-1:0][14-1:0]                   dac_dat_o
);

// digital loopback DAC -> ADC
calib_pkg::sample_t [NCH-1:0] lpb_dat;
logic [NCH-1:0]               lpb_vld;

calib_cfg_if #(.NCH (NCH)) cfg ();

//////////////////////////////////////////////////////////////////////
// register block
//////////////////////////////////////////////////////////////////////

calib_regs #(.NCH (NCH)) calib_regs (
  .adc_clk          (adc_clk),
  .top_rst          (top_rst),
  .s_axil_awaddr_i  (s_axil_awaddr_i),
  .s_axil_awvalid_i (s_axil_awvalid_i),
  .s_axil_awready_o (s_axil_awready_o),
  .s_axil_wdata_i   (s_axil_wdata_i),
  .s_axil_wvalid_i  (s_axil_wvalid_i),
  .s_axil_wready_o  (s_axil_wready_o),
  .s_axil_bresp_o   (s_axil_bresp_o),
  .s_axil_bvalid_o  (s_axil_bvalid_o),
  .s_axil_bready_i  (s_axil_bready_i),
  .s_axil_araddr_i  (s_axil_araddr_i),
  .s_axil_arvalid_i (s_axil_arvalid_i),
  .s_axil_arready_o (s_axil_arready_o),
  .s_axil_rdata_o   (s_axil_rdata_o),
  .s_axil_rresp_o   (s_axil_rresp_o),
  .s_axil_rvalid_o  (s_axil_rvalid_o),
  .s_axil_rready_i  (s_axil_rready_i),
  .cfg              (cfg.regs)
);

//////////////////////////////////////////////////////////////////////
// channel banks
//////////////////////////////////////////////////////////////////////

adc_bank #(.NCH (NCH)) adc_bank (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .adc_dat_i (adc_dat_i),
  .lpb_dat_i (lpb_dat),
  .lpb_vld_i (lpb_vld),
  .cfg       (cfg.chan),
  .osc_dat_o (osc_dat_o),
  .osc_vld_o (osc_vld_o)
);

dac_bank #(.NCH (NCH)) dac_bank (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .gen_dat_i (gen_dat_i),
  .gen_vld_i (gen_vld_i),
  .cfg       (cfg.chan),
  .lpb_dat_o (lpb_dat),
  .lpb_vld_o (lpb_vld),
  .dac_dat_o (dac_dat_o)
);

endmodule: rp_analog_top

// ==== tb_rp_analog.sv ====
module tb_rp_analog;

timeunit 1ns;
timeprecision 100ps;

localparam int unsigned NCH        = 2;
localparam int unsigned CLK_PERIOD = 8;
localparam int unsigned N_SAMP     = 200;
// budget for every register access, including the long stalls
localparam int unsigned N_AXI      = 80;
localparam int unsigned AXI_CYC    = 14;
localparam int unsigned STIM_CYC   = 8 * N_SAMP + N_AXI * AXI_CYC + 20;
localparam logic [31:0] RAND_SEED  = 32'h378f_57e5;
localparam longint      SMP_MAX    = 8191;
localparam longint      SMP_MIN    = -8192;
// cycles after a settings change before outputs are compared
localparam logic [3:0]  SETTLE_CYC = 4'd8;

logic                                     adc_clk;
logic                                     top_rst;
logic [calib_pkg::AXIL_AW-1:0]            awaddr;
logic                                     awvalid;
logic                                     awready;
logic [calib_pkg::AXIL_DW-1:0]            wdata;
logic                                     wvalid;
logic                                     wready;
logic [1:0]                               bresp;
logic                                     bvalid;
logic                                     bready;
logic [calib_pkg::AXIL_AW-1:0]            araddr;
logic                                     arvalid;
logic                                     arready;
logic [calib_pkg::AXIL_DW-1:0]            rdata;
logic [1:0]                               rresp;
logic                                     rvalid;
logic                                     rready;
logic [NCH-1:0][calib_pkg::ADC_RAW_W-1:0] adc_dat;
calib_pkg::sample_t [NCH-1:0]             gen_dat;
logic [NCH-1:0]                           gen_vld;
calib_pkg::sample_t [NCH-1:0]             osc_dat;
logic [NCH-1:0]                           osc_vld;
logic [NCH-1:0][13:0]                     dac_dat;

// shadow copy of the settings, written together with the DUT
calib_pkg::gain_t   sh_adc_mul [NCH];
calib_pkg::offset_t sh_adc_sum [NCH];
calib_pkg::gain_t   sh_dac_mul [NCH];
calib_pkg::offset_t sh_dac_sum [NCH];
logic [NCH-1:0]     sh_loop;
logic               cfg_busy;
logic [3:0]         settle;
logic               chk_on;

// input history where index n holds the input seen n+1 edges back
logic [NCH-1:0][calib_pkg::ADC_RAW_W-1:0] adc_h  [4];
calib_pkg::sample_t [NCH-1:0]             gen_h  [4];
logic [NCH-1:0]                           gvld_h [4];

calib_pkg::sample_t [NCH-1:0] exp_osc_dat;
logic [NCH-1:0]               exp_osc_vld;
logic [NCH-1:0][13:0]         exp_dac;

rp_analog_top #(.NCH (NCH)) rp_analog_top_inst (
  .adc_clk          (adc_clk),
  .top_rst          (top_rst),
  .s_axil_awaddr_i  (awaddr),
  .s_axil_awvalid_i (awvalid),
  .s_axil_awready_o (awready),
  .s_axil_wdata_i   (wdata),
  .s_axil_wvalid_i  (wvalid),
  .s_axil_wready_o  (wready),
  .s_axil_bresp_o   (bresp),
  .s_axil_bvalid_o  (bvalid),
  .s_axil_bready_i  (bready),
  .s_axil_araddr_i  (araddr),
  .s_axil_arvalid_i (arvalid),
  .s_axil_arready_o (arready),
  .s_axil_rdata_o   (rdata),
  .s_axil_rresp_o   (rresp),
  .s_axil_rvalid_o  (rvalid),
  .s_axil_rready_i  (rready),
  .adc_dat_i        (adc_dat),
  .gen_dat_i        (gen_dat),
  .gen_vld_i        (gen_vld),
  .osc_dat_o        (osc_dat),
  .osc_vld_o        (osc_vld),
  .dac_dat_o        (dac_dat)
);

initial adc_clk = 1'b0;
always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

//////////////////////////////////////////////////////////////////////
// error reporting
//////////////////////////////////////////////////////////////////////

task automatic stop_on_error();
  $display("** FAIL **");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic report_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
  $display("[FAIL] %s got 0x%h expected 0x%h", sig, got, exp);
  stop_on_error();
endtask

task automatic report_error(input string what);
  $display("error: %s", what);
  stop_on_error();
endtask

// watchdog sized from the whole stimulus
initial begin
  #((STIM_CYC + 1000) * CLK_PERIOD);
  report_error("watchdog expired before the test sequence finished");
end

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

// x * gain >>> frac + offset clamped to the sample range
function automatic calib_pkg::sample_t apply_cal(input calib_pkg::sample_t x,
                                                 input calib_pkg::gain_t g,
                                                 input calib_pkg::offset_t o);
  longint prod;
  longint res;
  prod = longint'(x) * longint'(g);
  res  = (prod >>> calib_pkg::GAIN_FRAC) + longint'(o);
  if (res > SMP_MAX) res = SMP_MAX;
  else if (res < SMP_MIN) res = SMP_MIN;
  return calib_pkg::sample_t'(res);
endfunction

// top bit kept, rest inverted, low two pin bits unused
function automatic calib_pkg::sample_t raw_to_sample(input logic [15:0] raw);
  return {raw[15], ~raw[14:2]};
endfunction

// inverse of the pin coding for stimulus
function automatic logic [15:0] sample_to_raw(input calib_pkg::sample_t s,
                                              input logic [1:0] pad);
  return {s[13], ~s[12:0], pad};
endfunction

function automatic logic [13:0] dac_code(input calib_pkg::sample_t s);
  return {s[13], ~s[12:0]};
endfunction

always @(posedge adc_clk) begin
  adc_h[0]  <= adc_dat;
  gen_h[0]  <= gen_dat;
  gvld_h[0] <= gen_vld;
  for (int i = 1; i < 4; i++) begin
    adc_h[i]  <= adc_h[i-1];
    gen_h[i]  <= gen_h[i-1];
    gvld_h[i] <= gvld_h[i-1];
  end
end

// restarts on every settings change
always @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    settle <= '0;
  end else if (cfg_busy) begin
    settle <= '0;
  end else if (settle != SETTLE_CYC) begin
    settle <= settle + 4'd1;
  end
end

assign chk_on = (settle == SETTLE_CYC);

// adc path 3 cycles, loopback 4, dac pins 3
always_comb begin
  for (int c = 0; c < NCH; c++) begin
    if (sh_loop[c]) begin
      exp_osc_dat[c] = apply_cal(apply_cal(gen_h[3][c], sh_dac_mul[c], sh_dac_sum[c]),
                                 sh_adc_mul[c], sh_adc_sum[c]);
      exp_osc_vld[c] = gvld_h[3][c];
    end else begin
      exp_osc_dat[c] = apply_cal(raw_to_sample(adc_h[2][c]), sh_adc_mul[c], sh_adc_sum[c]);
      exp_osc_vld[c] = 1'b1;
    end
    exp_dac[c] = dac_code(apply_cal(gen_h[2][c], sh_dac_mul[c], sh_dac_sum[c]));
  end
end

for (genvar c = 0; c < NCH; c++) begin: g_chk

  ast_osc_vld: assert property (@(posedge adc_clk) disable iff (top_rst)
    chk_on |-> osc_vld[c] == exp_osc_vld[c])
    else report_mismatch($sformatf("osc_vld_o[%0d]", c),
                         32'($sampled(osc_vld[c])), 32'($sampled(exp_osc_vld[c])));

  ast_osc_dat: assert property (@(posedge adc_clk) disable iff (top_rst)
    chk_on && exp_osc_vld[c] |-> osc_dat[c] == exp_osc_dat[c])
    else report_mismatch($sformatf("osc_dat_o[%0d]", c),
                         32'($sampled(osc_dat[c])), 32'($sampled(exp_osc_dat[c])));

  ast_dac_new: assert property (@(posedge adc_clk) disable iff (top_rst)
    chk_on && gvld_h[2][c] |-> dac_dat[c] == exp_dac[c])
    else report_mismatch($sformatf("dac_dat_o[%0d]", c),
                         32'($sampled(dac_dat[c])), 32'($sampled(exp_dac[c])));

  // pin code holds without a valid sample
  ast_dac_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
    chk_on && !gvld_h[2][c] |-> $stable(dac_dat[c]))
    else report_mismatch($sformatf("dac_dat_o[%0d]", c),
                         32'($sampled(dac_dat[c])), 32'($past(dac_dat[c])));

end: g_chk

//////////////////////////////////////////////////////////////////////
// AXI4-Lite master
//////////////////////////////////////////////////////////////////////

// handshakes sampled on the falling edge and drives 1 ns after rising
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         input int unsigned hold);
  @(posedge adc_clk);
  #1;
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wvalid  = 1'b1;
  @(negedge adc_clk);
  while (!(awready && wready)) @(negedge adc_clk);
  @(posedge adc_clk);
  #1;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  // response must wait while bready is held low
  repeat (hold) begin
    @(negedge adc_clk);
    assert (bvalid) else report_error("bvalid dropped while bready was low");
    assert (bresp == 2'b00) else report_mismatch("s_axil_bresp_o", 32'(bresp), 32'h0);
    assert (!awready && !wready) else report_error("write ready while a response was pending");
  end
  @(posedge adc_clk);
  #1;
  bready = 1'b1;
  @(negedge adc_clk);
  assert (bvalid) else report_error("no write response when bready rose");
  @(posedge adc_clk);
  #1;
  bready = 1'b0;
endtask

task automatic read_reg(input logic [7:0] addr, input int unsigned hold,
                        output logic [31:0] data);
  logic [31:0] first;
  @(posedge adc_clk);
  #1;
  araddr  = addr;
  arvalid = 1'b1;
  @(negedge adc_clk);
  while (!arready) @(negedge adc_clk);
  @(posedge adc_clk);
  #1;
  arvalid = 1'b0;
  @(negedge adc_clk);
  assert (rvalid) else report_error("rvalid missing one cycle after the read was accepted");
  first = rdata;
  repeat (hold) begin
    @(negedge adc_clk);
    assert (rvalid) else report_error("rvalid dropped while rready was low");
    assert (rdata == first) else report_mismatch("s_axil_rdata_o", rdata, first);
    assert (!arready) else report_error("arready high while read data was pending");
  end
  @(posedge adc_clk);
  #1;
  rready = 1'b1;
  @(negedge adc_clk);
  assert (rvalid && rdata == first) else report_mismatch("s_axil_rdata_o", rdata, first);
  assert (rresp == 2'b00) else report_mismatch("s_axil_rresp_o", 32'(rresp), 32'h0);
  data = first;
  @(posedge adc_clk);
  #1;
  rready = 1'b0;
endtask

task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp,
                         input int unsigned hold);
  logic [31:0] rd;
  read_reg(addr, hold, rd);
  assert (rd == exp)
    else report_mismatch($sformatf("s_axil_rdata_o at 0x%h", addr), rd, exp);
endtask

// all mapped registers against the shadow
task automatic verify_regs(input int unsigned max_hold);
  logic [7:0] adc_base;
  logic [7:0] dac_base;
  check_reg(calib_pkg::REG_ID, calib_pkg::CALIB_ID, $urandom_range(max_hold, 0));
  check_reg(calib_pkg::REG_LOOP, 32'(sh_loop), $urandom_range(max_hold, 0));
  for (int c = 0; c < NCH; c++) begin
    adc_base = calib_pkg::REG_ADC_BASE + 8'(c * calib_pkg::REG_CH_STRIDE);
    dac_base = calib_pkg::REG_DAC_BASE + 8'(c * calib_pkg::REG_CH_STRIDE);
    check_reg(adc_base + 8'(calib_pkg::REG_MUL_OFS), 32'(sh_adc_mul[c]),
              $urandom_range(max_hold, 0));
    check_reg(adc_base + 8'(calib_pkg::REG_SUM_OFS), 32'(sh_adc_sum[c]),
              $urandom_range(max_hold, 0));
    check_reg(dac_base + 8'(calib_pkg::REG_MUL_OFS), 32'(sh_dac_mul[c]),
              $urandom_range(max_hold, 0));
    check_reg(dac_base + 8'(calib_pkg::REG_SUM_OFS), 32'(sh_dac_sum[c]),
              $urandom_range(max_hold, 0));
  end
endtask

// gain and offset of one channel on the adc or dac side
task automatic set_cal(input bit dac_side, input int unsigned c,
                       input calib_pkg::gain_t g, input calib_pkg::offset_t o);
  logic [7:0] base;
  base = (dac_side ? calib_pkg::REG_DAC_BASE : calib_pkg::REG_ADC_BASE)
       + 8'(c * calib_pkg::REG_CH_STRIDE);
  cfg_busy = 1'b1;
  write_reg(base + 8'(calib_pkg::REG_MUL_OFS), 32'(g), $urandom_range(3, 0));
  write_reg(base + 8'(calib_pkg::REG_SUM_OFS), 32'(o), $urandom_range(3, 0));
  if (dac_side) begin
    sh_dac_mul[c] = g;
    sh_dac_sum[c] = o;
  end else begin
    sh_adc_mul[c] = g;
    sh_adc_sum[c] = o;
  end
  cfg_busy = 1'b0;
endtask

task automatic set_loop(input logic [NCH-1:0] bits);
  cfg_busy = 1'b1;
  write_reg(calib_pkg::REG_LOOP, 32'(bits), $urandom_range(3, 0));
  sh_loop  = bits;
  cfg_busy = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// sample stimulus
//////////////////////////////////////////////////////////////////////

// full scale ends half the time
function automatic calib_pkg::sample_t pick_extreme();
  case ($urandom_range(3, 0))
    0:       return 14'sh1fff;
    1:       return 14'sh2000;
    default: return calib_pkg::sample_t'($urandom);
  endcase
endfunction

task automatic drive_samples(input int unsigned n, input bit extreme);
  repeat (n) begin
    @(posedge adc_clk);
    #1;
    for (int c = 0; c < NCH; c++) begin
      if (extreme) begin
        adc_dat[c] = sample_to_raw(pick_extreme(), 2'($urandom));
        gen_dat[c] = pick_extreme();
      end else begin
        adc_dat[c] = 16'($urandom);
        gen_dat[c] = calib_pkg::sample_t'($urandom);
      end
      gen_vld[c] = 1'($urandom);
    end
  end
endtask

task automatic check_reset_state();
  assert (osc_vld == '0) else report_mismatch("osc_vld_o", 32'(osc_vld), 32'h0);
  assert (!bvalid) else report_error("bvalid high during reset");
  assert (!rvalid) else report_error("rvalid high during reset");
  for (int c = 0; c < NCH; c++) begin
    assert (dac_dat[c] == '0)
      else report_mismatch($sformatf("dac_dat_o[%0d]", c), 32'(dac_dat[c]), 32'h0);
  end
endtask

//////////////////////////////////////////////////////////////////////
// test sequence
//////////////////////////////////////////////////////////////////////

initial begin
  logic [31:0] rd;
  void'($urandom(RAND_SEED));
  top_rst  = 1'b1;
  cfg_busy = 1'b0;
  awaddr   = '0;
  awvalid  = 1'b0;
  wdata    = '0;
  wvalid   = 1'b0;
  bready   = 1'b0;
  araddr   = '0;
  arvalid  = 1'b0;
  rready   = 1'b0;
  adc_dat  = '0;
  gen_dat  = '0;
  gen_vld  = '0;
  sh_loop  = '0;
  for (int c = 0; c < NCH; c++) begin
    sh_adc_mul[c] = calib_pkg::GAIN_UNITY;
    sh_adc_sum[c] = '0;
    sh_dac_mul[c] = calib_pkg::GAIN_UNITY;
    sh_dac_sum[c] = '0;
  end

  // reset over two rising edges
  @(posedge adc_clk);
  @(negedge adc_clk);
  check_reset_state();
  @(posedge adc_clk);
  #1;
  top_rst = 1'b0;

  // reset values, then plain conversion at unity gain
  verify_regs(3);
  drive_samples(20, 1'b0);

  // random adc calibration
  for (int c = 0; c < NCH; c++) begin
    set_cal(1'b0, c, calib_pkg::gain_t'($urandom), calib_pkg::offset_t'($urandom));
  end
  verify_regs(3);
  drive_samples(N_SAMP, 1'b0);

  // random dac calibration with toggling gen valid
  for (int c = 0; c < NCH; c++) begin
    set_cal(1'b1, c, calib_pkg::gain_t'($urandom), calib_pkg::offset_t'($urandom));
  end
  drive_samples(N_SAMP, 1'b0);

  // loopback on one channel at a time
  set_loop(2'b01);
  drive_samples(N_SAMP, 1'b0);
  set_loop(2'b10);
  drive_samples(N_SAMP, 1'b0);

  // saturation with the largest gains and offsets
  set_cal(1'b0, 0, 16'sh7fff, 14'sh1fff);
  set_cal(1'b0, 1, 16'sh8000, 14'sh2000);
  set_cal(1'b1, 0, 16'sh7fff, 14'sh0000);
  set_cal(1'b1, 1, 16'sh8000, 14'sh0000);
  set_loop(2'b00);
  drive_samples(N_SAMP, 1'b1);
  set_loop(2'b11);
  drive_samples(N_SAMP, 1'b1);

  // long stalls and unmapped addresses
  read_reg(8'h50, 6, rd);
  assert (rd == 32'h0) else report_mismatch("s_axil_rdata_o at 0x50", rd, 32'h0);
  read_reg(8'h90, 6, rd);
  assert (rd == 32'h0) else report_mismatch("s_axil_rdata_o at 0x90", rd, 32'h0);
  write_reg(8'h50, 32'hffff_ffff, 6);
  write_reg(8'h08, 32'hffff_ffff, 6);
  write_reg(8'h90, 32'h0000_1234, 6);
  verify_regs(6);
  drive_samples(N_SAMP, 1'b0);

  $display("** PASS **");
  $finish;
end

endmodule: tb_rp_analog

// ==== sim.f ====
calib_pkg.sv
calib_cfg_if.sv
calib_regs.sv
linear_calib.sv
adc_bank.sv
dac_bank.sv
rp_analog_top.sv
tb_rp_analog.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the analog data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rp_analog
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir "$OBJ" -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF '** PASS **' "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
